// ==== hdl/dot_cfg.svh ====
/*
 * Dot-product engine configuration
 * Operand, frame length and accumulator widths, plus the depth of the
 * product pipeline
 */

`ifndef DOT_CFG_SVH
`define DOT_CFG_SVH

// Signed operand width
`define DOT_DATA_W 8

// Frame length width, a frame holds 1 to 63 items
`define DOT_LEN_W 6

// Signed accumulator width, wraps on overflow
`define DOT_ACC_W 24

// Depth of the product delay line, 1 or more
`define DOT_MUL_STAGES 3

`endif

// ==== hdl/dot_pkg.sv ====
/*
 * Dot-product engine types
 * Opcode and state enums, the sample pair and the product record that
 * travels down the multiplier delay line
 */

`include "dot_cfg.svh"

package dot_pkg;

  // ------------------------------------------------------------------------
  // Enums
  // ------------------------------------------------------------------------

  // Per-item operation on the product
  typedef enum logic {
    OP_ADD = 1'b0,
    OP_SUB = 1'b1
  } dot_op_e;

  // Frame sequencer states
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_RUN   = 2'd1,
    ST_DRAIN = 2'd2
  } dot_state_e;

  // ------------------------------------------------------------------------
  // Structs
  // ------------------------------------------------------------------------

  // Input sample, opcode plus two signed operands (17 bits)
  typedef struct packed {
    dot_op_e                        op;
    logic signed [`DOT_DATA_W-1:0]  a;
    logic signed [`DOT_DATA_W-1:0]  b;
  } dot_sample_t;

  // Product in flight, opcode plus full-width signed product (17 bits)
  typedef struct packed {
    dot_op_e                          op;
    logic signed [2*`DOT_DATA_W-1:0]  prod;
  } dot_product_t;

endpackage

// ==== hdl/br_delay_valid.sv ====
/*
 * Valid-qualified delay line
 * Delays a valid and its data by NumStages registers. Valid bits are
 * reset, data bits only load when the stage feeding them is valid.
 */

module br_delay_valid #(
  parameter int Width     = 1,
  parameter int NumStages = 0
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           in_valid,
  input  logic [Width-1:0]               in,
  output logic                           out_valid,
  // Last stage, NumStages cycles after the input
  output logic [Width-1:0]               out,
  // Per-stage view, index 0 is the input itself
  output logic [NumStages:0]             out_valid_stages,
  output logic [NumStages:0][Width-1:0]  out_stages
);

  logic [NumStages:0]            stage_valid;
  logic [NumStages:0][Width-1:0] stage;

  // Stage 0 is the raw input
  assign stage_valid[0] = in_valid;
  assign stage[0]       = in;

  // Loop is empty with zero stages, which leaves a pass-through
  for (genvar i = 1; i <= NumStages; i++) begin : gen_stages
    // Valid pipe, cleared by reset
    always_ff @(posedge clk) begin
      if (reset) begin
        stage_valid[i] <= 1'b0;
      end else begin
        stage_valid[i] <= stage_valid[i-1];
      end
    end

    // Data pipe, holds unless the previous stage carries an item
    always_ff @(posedge clk) begin
      if (stage_valid[i-1]) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  assign out_valid        = stage_valid[NumStages];
  assign out              = stage[NumStages];
  assign out_valid_stages = stage_valid;
  assign out_stages       = stage;

endmodule

// ==== hdl/dot_sequencer.sv ====
/*
 * Frame sequencer
 * Starts a frame on a nonzero-length start, gates sample acceptance and
 * pulses done once the final product has been accumulated
 */

`include "dot_cfg.svh"

module dot_sequencer import dot_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  start,
  input  logic [`DOT_LEN_W-1:0] frame_len,
  input  logic                  last_in,
  input  logic                  last_out,
  output logic                  load,
  output logic                  accept,
  output logic                  busy,
  output logic                  done
);

  dot_state_e state;
  dot_state_e state_next;

  // Start only counts in idle, zero length is refused
  assign load = (state == ST_IDLE) && start && (frame_len != '0);

  // ------------------------------------------------------------------------
  // Next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (load) state_next = ST_RUN;
      end
      // Final sample taken, wait for its product
      ST_RUN: begin
        if (last_in) state_next = ST_DRAIN;
      end
      ST_DRAIN: begin
        if (last_out) state_next = ST_IDLE;
      end
      default: state_next = ST_IDLE;
    endcase
  end

  // ------------------------------------------------------------------------
  // State and done registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_IDLE;
      done  <= 1'b0;
    end else begin
      state <= state_next;
      // Lands in the cycle after the last product, same edge as idle
      done  <= (state == ST_DRAIN) && last_out;
    end
  end

  assign accept = (state == ST_RUN);
  assign busy   = (state != ST_IDLE);

endmodule

// ==== hdl/dot_counter.sv ====
/*
 * Frame item counters
 * Holds the frame length and counts accepted samples and emerging
 * products, flagging the item that completes each count
 */

`include "dot_cfg.svh"

module dot_counter import dot_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  load,
  input  logic [`DOT_LEN_W-1:0] frame_len,
  input  logic                  accept,
  input  logic                  sample_valid,
  input  logic                  prod_valid,
  output logic                  last_in,
  output logic                  last_out
);

  logic [`DOT_LEN_W-1:0] len_q;
  logic [`DOT_LEN_W-1:0] in_count;
  logic [`DOT_LEN_W-1:0] out_count;
  logic [`DOT_LEN_W-1:0] in_next;
  logic [`DOT_LEN_W-1:0] out_next;
  logic                  take;

  // Sample is taken only inside a frame
  assign take     = accept && sample_valid;
  assign in_next  = in_count + 1'b1;
  assign out_next = out_count + 1'b1;

  always_ff @(posedge clk) begin
    if (reset) begin
      len_q     <= '0;
      in_count  <= '0;
      out_count <= '0;
    end else if (load) begin
      // New frame, both counts restart
      len_q     <= frame_len;
      in_count  <= '0;
      out_count <= '0;
    end else begin
      if (take)       in_count  <= in_next;
      if (prod_valid) out_count <= out_next;
    end
  end

  // Item number len_q completes the count
  assign last_in  = take && (in_next == len_q);
  assign last_out = prod_valid && (out_next == len_q);

endmodule

// ==== hdl/dot_mac.sv ====
/*
 * Multiply-accumulate datapath
 * Signed multiply of each accepted pair, a delay line standing in for a
 * pipelined multiplier, then a wrapping signed accumulator
 */

`include "dot_cfg.svh"

module dot_mac import dot_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         load,
  input  logic                         accept,
  input  logic                         sample_valid,
  input  dot_sample_t                  sample,
  output logic                         prod_valid,
  output logic signed [`DOT_ACC_W-1:0] result
);

  dot_product_t                 prod_in;
  dot_product_t                 prod_out;
  logic                         take;
  logic signed [`DOT_ACC_W-1:0] prod_ext;
  logic signed [`DOT_ACC_W-1:0] acc;

  // ------------------------------------------------------------------------
  // Multiply stage
  // ------------------------------------------------------------------------
  assign take         = accept && sample_valid;
  assign prod_in.op   = sample.op;
  // Both operands signed, full 16-bit product
  assign prod_in.prod = sample.a * sample.b;

  // Opcode rides along with its product
  br_delay_valid #(
    .Width     ($bits(dot_product_t)),
    .NumStages (`DOT_MUL_STAGES)
  ) mul_delay_i (
    .clk              (clk),
    .reset            (reset),
    .in_valid         (take),
    .in               (prod_in),
    .out_valid        (prod_valid),
    .out              (prod_out),
    .out_valid_stages (),
    .out_stages       ()
  );

  // ------------------------------------------------------------------------
  // Accumulate stage
  // ------------------------------------------------------------------------

  // Sign extension to accumulator width
  assign prod_ext = prod_out.prod;

  always_ff @(posedge clk) begin
    if (reset || load) begin
      acc <= '0;
    end else if (prod_valid) begin
      // No saturation, sum wraps
      if (prod_out.op == OP_SUB) acc <= acc - prod_ext;
      else                       acc <= acc + prod_ext;
    end
  end

  // Held until the next load
  assign result = acc;

endmodule

// ==== hdl/dot_engine.sv ====
/*
 * Dot-product engine top level
 * Connects the frame sequencer, the item counters and the MAC datapath
 */

`include "dot_cfg.svh"

module dot_engine import dot_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  logic [`DOT_LEN_W-1:0]        frame_len,
  input  logic                         sample_valid,
  input  dot_sample_t                  sample,
  output logic                         busy,
  output logic                         done,
  output logic signed [`DOT_ACC_W-1:0] result
);

  // Control between the blocks
  logic load;
  logic accept;
  logic last_in;
  logic last_out;
  logic prod_valid;

  // ------------------------------------------------------------------------
  // Frame control
  // ------------------------------------------------------------------------
  dot_sequencer sequencer_i (
    .clk       (clk),
    .reset     (reset),
    .start     (start),
    .frame_len (frame_len),
    .last_in   (last_in),
    .last_out  (last_out),
    .load      (load),
    .accept    (accept),
    .busy      (busy),
    .done      (done)
  );

  dot_counter counter_i (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .frame_len    (frame_len),
    .accept       (accept),
    .sample_valid (sample_valid),
    .prod_valid   (prod_valid),
    .last_in      (last_in),
    .last_out     (last_out)
  );

  // ------------------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------------------
  dot_mac mac_i (
    .clk          (clk),
    .reset        (reset),
    .load         (load),
    .accept       (accept),
    .sample_valid (sample_valid),
    .sample       (sample),
    .prod_valid   (prod_valid),
    .result       (result)
  );

endmodule

// ==== bench/dot_engine_properties.sv ====
/*
 * Dot-product engine properties
 * Done pulse shape, busy at done, zero-length starts and done only
 * after a frame was loaded
 */

`include "dot_cfg.svh"

module dot_engine_properties import dot_pkg::*; (
  input logic                  clk,
  input logic                  reset,
  input logic                  start,
  input logic [`DOT_LEN_W-1:0] frame_len,
  input logic                  load,
  input logic                  busy,
  input logic                  done
);

  // Set by a load, cleared by the done that ends the frame
  logic frame_open;

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_open <= 1'b0;
    end else if (load) begin
      frame_open <= 1'b1;
    end else if (done) begin
      frame_open <= 1'b0;
    end
  end

  // ------------------------------------------------------------------------
  // Assertions
  // ------------------------------------------------------------------------
  done_single_cycle: assert property (@(posedge clk) disable iff (reset)
    done |=> !done) else $error("done held longer than one cycle");

  // Sequencer is already back in idle
  done_busy_low: assert property (@(posedge clk) disable iff (reset)
    done |-> !busy) else $error("busy still high at done");

  done_after_load: assert property (@(posedge clk) disable iff (reset)
    done |-> frame_open) else $error("done without a started frame");

  zero_len_refused: assert property (@(posedge clk) disable iff (reset)
    (start && !busy && frame_len == '0) |=> !busy) else $error("zero-length start accepted");

endmodule

bind dot_engine dot_engine_properties props_i (
  .clk       (clk),
  .reset     (reset),
  .start     (start),
  .frame_len (frame_len),
  .load      (load),
  .busy      (busy),
  .done      (done)
);

// ==== bench/dot_engine_tb.sv ====
/*
 * Dot-product engine testbench
 * Applies a table of frames, models each expected sum and checks the
 * result, the done latency and that stray samples are ignored
 */

`include "dot_cfg.svh"

module dot_engine_tb import dot_pkg::*; ();

  // Frame flavours in the table
  typedef enum logic [1:0] {
    FR_FIXED,
    FR_RAND_OPS,
    FR_RAND_ALL,
    FR_ZERO_START
  } frame_kind_e;

  // One table row, gap and sub masks repeat every 8 items
  typedef struct packed {
    frame_kind_e                    kind;
    logic [`DOT_LEN_W-1:0]          len;
    logic [7:0]                     gap_mask;
    logic [7:0]                     sub_mask;
    logic signed [`DOT_DATA_W-1:0]  a_base;
    logic signed [`DOT_DATA_W-1:0]  b_base;
    logic                           junk;
  } frame_t;

  localparam int          NUM_FRAMES   = 12;
  localparam int          DONE_TIMEOUT = 200;
  localparam dot_sample_t JUNK_SAMPLE  = '{OP_SUB, 8'sd77, -8'sd55};

  logic                         clk;
  logic                         reset;
  logic                         start;
  logic [`DOT_LEN_W-1:0]        frame_len;
  logic                         sample_valid;
  dot_sample_t                  sample;
  logic                         busy;
  logic                         done;
  logic signed [`DOT_ACC_W-1:0] result;

  frame_t      frames [NUM_FRAMES];
  dot_sample_t sent [$];
  integer      seed;
  int          errors;
  int          tests_run;
  int          tests_failed;
  bit          aborted;

  // Period 40
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  dot_engine dot_engine_i (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .frame_len    (frame_len),
    .sample_valid (sample_valid),
    .sample       (sample),
    .busy         (busy),
    .done         (done),
    .result       (result)
  );

  // ------------------------------------------------------------------------
  // Stimulus table
  // ------------------------------------------------------------------------
  function automatic void fill_table();
    // kind, len, gap mask, sub mask, a base, b base, junk
    frames[0]  = '{FR_FIXED,      6'd8,  8'h00, 8'h00, 8'sd3,    8'sd5,    1'b0};
    frames[1]  = '{FR_FIXED,      6'd12, 8'hA4, 8'h69, -8'sd20,  8'sd7,    1'b0};
    frames[2]  = '{FR_FIXED,      6'd6,  8'h12, 8'h0F, 8'sd100,  -8'sd90,  1'b1};
    frames[3]  = '{FR_ZERO_START, 6'd0,  8'h00, 8'h00, 8'sd0,    8'sd0,    1'b1};
    // Length-one frames back to back
    frames[4]  = '{FR_FIXED,      6'd1,  8'h00, 8'h00, -8'sd128, -8'sd128, 1'b0};
    frames[5]  = '{FR_FIXED,      6'd1,  8'h00, 8'hFF, 8'sd127,  -8'sd128, 1'b0};
    frames[6]  = '{FR_FIXED,      6'd5,  8'h00, 8'h00, 8'sd2,    8'sd2,    1'b0};
    frames[7]  = '{FR_RAND_OPS,   6'd63, 8'h00, 8'h00, 8'sd0,    8'sd0,    1'b0};
    frames[8]  = '{FR_RAND_ALL,   6'd0,  8'h22, 8'h00, 8'sd0,    8'sd0,    1'b0};
    frames[9]  = '{FR_RAND_ALL,   6'd0,  8'h81, 8'h00, 8'sd0,    8'sd0,    1'b1};
    frames[10] = '{FR_RAND_ALL,   6'd0,  8'h00, 8'h00, 8'sd0,    8'sd0,    1'b0};
    frames[11] = '{FR_RAND_OPS,   6'd63, 8'h10, 8'h00, 8'sd0,    8'sd0,    1'b0};
  endfunction

  // ------------------------------------------------------------------------
  // Helpers and reference model
  // ------------------------------------------------------------------------
  task automatic report_mismatch(input string what, input longint got, input longint exp);
    errors++;
    $display("FAIL %0t: %s is %0d, expected %0d", $time, what, got, exp);
  endtask

  // Signed sum of products, SUB items negated, wrapped to the accumulator
  task automatic model_sum(output logic signed [`DOT_ACC_W-1:0] expected);
    longint sum;
    longint prod;
    sum = 0;
    foreach (sent[i]) begin
      prod = longint'(sent[i].a) * longint'(sent[i].b);
      if (sent[i].op == OP_SUB) sum = sum - prod;
      else sum = sum + prod;
    end
    expected = sum[`DOT_ACC_W-1:0];
  endtask

  task automatic make_sample(input frame_t f, input int i, output dot_sample_t s);
    logic [31:0] r;
    if (f.kind == FR_FIXED) begin
      // Ramps away from the base values
      s.a  = f.a_base + `DOT_DATA_W'(3 * i);
      s.b  = f.b_base - `DOT_DATA_W'(2 * i);
      s.op = f.sub_mask[i % 8] ? OP_SUB : OP_ADD;
    end else begin
      r    = $random(seed);
      s.a  = r[`DOT_DATA_W-1:0];
      s.b  = r[2*`DOT_DATA_W-1:`DOT_DATA_W];
      s.op = r[2*`DOT_DATA_W] ? OP_SUB : OP_ADD;
    end
  endtask

  // ------------------------------------------------------------------------
  // One table row, entered and left on a falling edge
  // ------------------------------------------------------------------------
  task automatic run_frame(input int idx, input frame_t f);
    logic [`DOT_LEN_W-1:0]        len;
    logic signed [`DOT_ACC_W-1:0] expected;
    logic signed [`DOT_ACC_W-1:0] held;
    logic [31:0]                  r;
    dot_sample_t                  s;
    int                           errors_before;
    int                           cycles;
    errors_before = errors;
    len = f.len;
    if (f.kind == FR_RAND_ALL) begin
      r   = $random(seed);
      len = `DOT_LEN_W'((r[15:0] % 63) + 1);
    end
    if (f.kind == FR_ZERO_START) begin
      // Zero length must be refused, stray samples too
      held         = result;
      start        = 1'b1;
      frame_len    = '0;
      sample_valid = f.junk;
      sample       = JUNK_SAMPLE;
      repeat (4) begin
        @(negedge clk);
        start = 1'b0;
        if (busy) report_mismatch("busy after zero-length start", busy, 0);
        if (result !== held) report_mismatch("result after zero-length start", result, held);
      end
      sample_valid = 1'b0;
    end else begin
      sent.delete();
      start        = 1'b1;
      frame_len    = len;
      sample_valid = 1'b0;
      @(negedge clk);
      start = 1'b0;
      if (!busy) report_mismatch("busy after start", busy, 1);
      for (int i = 0; i < int'(len); i++) begin
        if (f.gap_mask[i % 8]) begin
          sample_valid = 1'b0;
          @(negedge clk);
        end
        make_sample(f, i, s);
        sample       = s;
        sample_valid = 1'b1;
        sent.push_back(s);
        @(negedge clk);
      end
      // Drain, junk strobes here land in ST_DRAIN
      sample_valid = f.junk;
      sample       = JUNK_SAMPLE;
      cycles       = 1;
      while (!done && cycles <= DONE_TIMEOUT) begin
        @(negedge clk);
        cycles++;
      end
      if (!done) begin
        $display("Timeout: no done within %0d cycles in test %0d", DONE_TIMEOUT, idx);
        errors++;
        aborted = 1'b1;
      end else begin
        model_sum(expected);
        if (result !== expected) report_mismatch("result", result, expected);
        if (cycles != `DOT_MUL_STAGES + 1)
          report_mismatch("done latency", cycles, `DOT_MUL_STAGES + 1);
        if (busy) report_mismatch("busy at done", busy, 0);
        if (f.junk) begin
          // Idle samples after the frame leave the result alone
          held = result;
          repeat (3) begin
            @(negedge clk);
            if (result !== held) report_mismatch("result after idle samples", result, held);
            if (busy) report_mismatch("busy after idle samples", busy, 0);
          end
        end
      end
      sample_valid = 1'b0;
    end
    tests_run++;
    if (errors != errors_before) tests_failed++;
    $display("Test %0d finished: %0d items, result %0d, %0d errors",
             idx, len, result, errors - errors_before);
  endtask

  // ------------------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------------------
  initial begin
    seed         = 32'h9172;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    frame_len    = '0;
    sample_valid = 1'b0;
    sample       = '0;
    fill_table();
    repeat (16) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    // Quiet state straight after reset
    if (busy) report_mismatch("busy after reset", busy, 0);
    if (done) report_mismatch("done after reset", done, 0);
    if (result !== '0) report_mismatch("result after reset", result, 0);
    tests_run++;
    if (errors != 0) tests_failed++;
    $display("Test 0 finished: reset state, %0d errors", errors);
    for (int t = 0; t < NUM_FRAMES && !aborted; t++) begin
      run_frame(t + 1, frames[t]);
    end
    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// ==== dot_engine.f ====
+incdir+hdl
hdl/dot_pkg.sv
hdl/br_delay_valid.sv
hdl/dot_sequencer.sv
hdl/dot_counter.sv
hdl/dot_mac.sv
hdl/dot_engine.sv
bench/dot_engine_properties.sv
bench/dot_engine_tb.sv

// ==== Makefile ====
# Verilator build, run and lint for the dot-product engine

VERILATOR  ?= verilator
TOP        ?= dot_engine_tb
FILELIST   ?= dot_engine.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
FAIL_MSG   ?= Testbench failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
